//--- src/ldpc_row_pkg.sv
`default_nettype none

package ldpc_row_pkg;

	////////////////////////////////////////////////////////////
	// message format

	localparam int QUAN_SIZE = 4; // bits per quantized message

	// sign-magnitude view of one message
	typedef struct packed {
		logic                 sign; // 1 = negative
		logic [QUAN_SIZE-2:0] mag;  // reliability level
	} msg_sm_t;

	// one message word, read as a raw table index or as sign/magnitude
	typedef union packed {
		logic [QUAN_SIZE-1:0] idx; // raw field, concatenated into lookup addresses
		msg_sm_t              sm;  // sign + magnitude
	} msg_t;

	////////////////////////////////////////////////////////////
	// table address widths

	// variable-node tables, two messages per address
	localparam int VN_ADDR_BW = 2 * QUAN_SIZE;

	// decision-node table, sign extension bit on top of two messages
	localparam int DN_ADDR_BW = 2 * QUAN_SIZE + 1;

	// shared write address sized for the widest table
	localparam int LUT_ADDR_BW = (VN_ADDR_BW > DN_ADDR_BW) ? VN_ADDR_BW : DN_ADDR_BW;

	////////////////////////////////////////////////////////////
	// table select, indexes bits of the write enable

	typedef enum logic [1:0] {
		LUT_F0 = 2'd0, // channel + first c2v
		LUT_F1 = 2'd1, // f0 result + second c2v
		LUT_DN = 2'd2  // decision node
	} stage_sel_e;

endpackage

`default_nettype wire

//--- src/row_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// one lane-parallel item between two stages
interface row_stage_if
	import ldpc_row_pkg::*;
#(
	parameter int LANES = 10
) ();

	logic valid; // item present, held until ready
	logic ready; // receiver takes it this cycle

	msg_t [LANES-1:0] t;          // f0 lookup result
	msg_t [LANES-1:0] c2v_1;      // second c2v, used by f1
	msg_t [LANES-1:0] c2v_2;      // third c2v, used by dnu
	msg_t [LANES-1:0] c2v_to_dnu; // decision check message
	logic [LANES-1:0] sign_ext;   // dnu sign extension per lane
	msg_t [LANES-1:0] v2c;        // f1 lookup result
	logic [LANES-1:0] sign_gen;   // sign of v2c

	// sending stage
	modport src (
		output valid, t, c2v_1, c2v_2, c2v_to_dnu, sign_ext, v2c, sign_gen,
		input  ready
	);

	// receiving stage
	modport dst (
		input  valid, t, c2v_1, c2v_2, c2v_to_dnu, sign_ext, v2c, sign_gen,
		output ready
	);

endinterface

`default_nettype wire

//--- src/ib_lut_ram.sv
`timescale 1ns/1ps
`default_nettype none

// writable IB lookup table, one registered read port per lane
module ib_lut_ram #(
	parameter int LANES   = 10,
	parameter int ADDR_BW = 8,
	parameter int DATA_BW = 4
) (
	input  logic                            clk,
	input  logic                            we,    // table update
	input  logic [ADDR_BW-1:0]              waddr,
	input  logic [DATA_BW-1:0]              wdata,
	input  logic                            en,    // low = hold read data
	input  logic [LANES-1:0][ADDR_BW-1:0]   raddr,
	output logic [LANES-1:0][DATA_BW-1:0]   rdata
);

	localparam int DEPTH = 1 << ADDR_BW; // full table, every address reachable

	logic [DATA_BW-1:0] mem [0:DEPTH-1]; // flop array, all lanes share it

	////////////////////////////////////////////////////////////
	// write side

	// refreshed between iterations only, lands at this edge
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// read side

	// one lookup per lane, registered
	// same-edge write not visible here, read gets old entry
	always_ff @(posedge clk) begin
		if (en) begin
			for (int l = 0; l < LANES; l++) begin
				rdata[l] <= mem[raddr[l]];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/vnu_f0_stage.sv
`timescale 1ns/1ps
`default_nettype none

// vnu f0: channel msg + first c2v -> t
module vnu_f0_stage
	import ldpc_row_pkg::*;
#(
	parameter int LANES = 10
) (
	input  logic                  read_clk,
	input  logic                  rst,
	// upstream handshake
	input  logic                  in_valid,
	output logic                  in_ready,
	// per-lane inputs
	input  msg_t [LANES-1:0]      ch_msg,
	input  msg_t [LANES-1:0]      c2v_0,
	input  msg_t [LANES-1:0]      c2v_1,
	input  msg_t [LANES-1:0]      c2v_2,
	input  msg_t [LANES-1:0]      c2v_to_dnu,
	input  logic [LANES-1:0]      dnu_sign_ext,
	// table update
	input  logic                  lut_we,
	input  logic [VN_ADDR_BW-1:0] lut_addr,
	input  logic [QUAN_SIZE-1:0]  lut_data,
	// to f1
	row_stage_if.src              out
);

	logic accept; // item taken this cycle
	logic out_v;  // stage holds an item

	logic [LANES-1:0][VN_ADDR_BW-1:0] raddr;
	logic [LANES-1:0][QUAN_SIZE-1:0]  t_rd; // registered lookup

	// fields carried for later stages
	msg_t [LANES-1:0] c2v_1_q;
	msg_t [LANES-1:0] c2v_2_q;
	msg_t [LANES-1:0] c2v_dn_q;
	logic [LANES-1:0] sext_q;

	////////////////////////////////////////////////////////////
	// handshake

	assign in_ready = !out_v || out.ready; // empty, or item leaves now
	assign accept   = in_valid && in_ready;

	always_ff @(posedge read_clk) begin
		if (rst) begin
			out_v <= 1'b0;
		end else if (accept) begin
			out_v <= 1'b1; // replaces any item leaving this cycle
		end else if (out.ready) begin
			out_v <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// lookup

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			raddr[l] = {ch_msg[l].idx, c2v_0[l].idx}; // channel msg in upper half
		end
	end

	ib_lut_ram #(
		.LANES   (LANES),
		.ADDR_BW (VN_ADDR_BW),
		.DATA_BW (QUAN_SIZE)
	) u_lut (
		.clk   (read_clk),
		.we    (lut_we),
		.waddr (lut_addr),
		.wdata (lut_data),
		.en    (accept), // stalled -> t held
		.raddr (raddr),
		.rdata (t_rd)
	);

	always_ff @(posedge read_clk) begin
		if (accept) begin
			c2v_1_q  <= c2v_1;
			c2v_2_q  <= c2v_2;
			c2v_dn_q <= c2v_to_dnu;
			sext_q   <= dnu_sign_ext;
		end
	end

	assign out.valid      = out_v;
	assign out.t          = t_rd;
	assign out.c2v_1      = c2v_1_q;
	assign out.c2v_2      = c2v_2_q;
	assign out.c2v_to_dnu = c2v_dn_q;
	assign out.sign_ext   = sext_q;
	assign out.v2c        = '0; // not produced yet on this hop
	assign out.sign_gen   = '0;

endmodule

`default_nettype wire

//--- src/vnu_f1_stage.sv
`timescale 1ns/1ps
`default_nettype none

// vnu f1: t + second c2v -> v2c, sign_gen
module vnu_f1_stage
	import ldpc_row_pkg::*;
#(
	parameter int LANES = 10
) (
	input  logic                  read_clk,
	input  logic                  rst,
	row_stage_if.dst              up, // from f0
	row_stage_if.src              dn, // to decision node
	// table update
	input  logic                  lut_we,
	input  logic [VN_ADDR_BW-1:0] lut_addr,
	input  logic [QUAN_SIZE-1:0]  lut_data
);

	logic accept;
	logic dn_v;

	logic [LANES-1:0][VN_ADDR_BW-1:0] raddr;
	logic [LANES-1:0][QUAN_SIZE-1:0]  v2c_rd;

	msg_t [LANES-1:0] c2v_2_q;
	msg_t [LANES-1:0] c2v_dn_q;
	logic [LANES-1:0] sext_q;

	////////////////////////////////////////////////////////////
	// handshake

	assign up.ready = !dn_v || dn.ready;
	assign accept   = up.valid && up.ready;

	always_ff @(posedge read_clk) begin
		if (rst) begin
			dn_v <= 1'b0;
		end else if (accept) begin
			dn_v <= 1'b1;
		end else if (dn.ready) begin
			dn_v <= 1'b0; // drained
		end
	end

	////////////////////////////////////////////////////////////
	// lookup

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			raddr[l] = {up.t[l].idx, up.c2v_1[l].idx};
		end
	end

	ib_lut_ram #(
		.LANES   (LANES),
		.ADDR_BW (VN_ADDR_BW),
		.DATA_BW (QUAN_SIZE)
	) u_lut (
		.clk   (read_clk),
		.we    (lut_we),
		.waddr (lut_addr),
		.wdata (lut_data),
		.en    (accept),
		.raddr (raddr),
		.rdata (v2c_rd)
	);

	// carried to dnu
	always_ff @(posedge read_clk) begin
		if (accept) begin
			c2v_2_q  <= up.c2v_2;
			c2v_dn_q <= up.c2v_to_dnu;
			sext_q   <= up.sign_ext;
		end
	end

	assign dn.valid      = dn_v;
	assign dn.v2c        = v2c_rd;
	assign dn.c2v_2      = c2v_2_q;
	assign dn.c2v_to_dnu = c2v_dn_q;
	assign dn.sign_ext   = sext_q;
	assign dn.t          = '0; // consumed here
	assign dn.c2v_1      = '0;

	// sign generation straight off the registered lookup
	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			dn.sign_gen[l] = dn.v2c[l].sm.sign;
		end
	end

	// f0 must hold its item while this stage stalls
	a_up_stable : assert property (@(posedge read_clk) disable iff (rst)
		up.valid && !up.ready |=> up.valid && $stable(up.t) && $stable(up.c2v_1)
			&& $stable(up.c2v_2) && $stable(up.c2v_to_dnu) && $stable(up.sign_ext));

endmodule

`default_nettype wire

//--- src/dnu_stage.sv
`timescale 1ns/1ps
`default_nettype none

// decision node mapping sign ext, c2v_2 and c2v_to_dnu to a hard decision
module dnu_stage
	import ldpc_row_pkg::*;
#(
	parameter int LANES = 10
) (
	input  logic                  read_clk,
	input  logic                  rst,
	row_stage_if.dst              up, // from f1
	// table update with one bit per entry
	input  logic                  lut_we,
	input  logic [DN_ADDR_BW-1:0] lut_addr,
	input  logic                  lut_data,
	// row outputs
	output logic                  out_valid,
	input  logic                  out_ready,
	output msg_t [LANES-1:0]      v2c,
	output logic [LANES-1:0]      sign_gen,
	output logic [LANES-1:0]      hard_decision
);

	logic accept;
	logic [LANES-1:0][DN_ADDR_BW-1:0] raddr;

	assign up.ready = !out_valid || out_ready;
	assign accept   = up.valid && up.ready;

	always_ff @(posedge read_clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			// sign ext picks the table half
			raddr[l] = {up.sign_ext[l], up.c2v_2[l].idx, up.c2v_to_dnu[l].idx};
		end
	end

	ib_lut_ram #(
		.LANES   (LANES),
		.ADDR_BW (DN_ADDR_BW),
		.DATA_BW (1)
	) u_lut (
		.clk   (read_clk),
		.we    (lut_we),
		.waddr (lut_addr),
		.wdata (lut_data),
		.en    (accept),
		.raddr (raddr),
		.rdata (hard_decision)
	);

	// v2c aligned with the decision of the same item
	always_ff @(posedge read_clk) begin
		if (accept) begin
			v2c      <= up.v2c;
			sign_gen <= up.sign_gen;
		end
	end

	// f1 must hold its item while the row output stalls
	a_up_hold : assert property (@(posedge read_clk) disable iff (rst)
		up.valid && !up.ready |=> up.valid && $stable(up.v2c) && $stable(up.sign_gen)
			&& $stable(up.c2v_2) && $stable(up.c2v_to_dnu) && $stable(up.sign_ext));

endmodule

`default_nettype wire

//--- src/row_vnu_top.sv
`timescale 1ns/1ps
`default_nettype none

// one row of variable-node processing, LANES lanes wide
module row_vnu_top
	import ldpc_row_pkg::*;
#(
	parameter int LANES = 10
) (
	input  logic                         read_clk,
	input  logic                         rst,
	// input items
	input  logic                         in_valid,
	output logic                         in_ready,
	input  logic [LANES*QUAN_SIZE-1:0]   ch_msg,
	input  logic [LANES*QUAN_SIZE-1:0]   c2v_0,
	input  logic [LANES*QUAN_SIZE-1:0]   c2v_1,
	input  logic [LANES*QUAN_SIZE-1:0]   c2v_2,
	input  logic [LANES*QUAN_SIZE-1:0]   c2v_to_dnu,
	input  logic [LANES-1:0]             dnu_sign_ext,
	// table refresh, one enable per stage_sel_e
	input  logic [2:0]                   lut_we,
	input  logic [LUT_ADDR_BW-1:0]       lut_addr,
	input  logic [QUAN_SIZE-1:0]         lut_data,
	// results
	output logic                         out_valid,
	input  logic                         out_ready,
	output logic [LANES*QUAN_SIZE-1:0]   v2c,
	output logic [LANES-1:0]             sign_gen,
	output logic [LANES-1:0]             hard_decision
);

	logic vn_addr_ok; // address inside the smaller vn tables
	logic we_f0, we_f1, we_dn;

	logic [1:0] occ; // items in flight, max 3
	logic in_acc, out_acc;

	////////////////////////////////////////////////////////////
	// table write decode

	assign vn_addr_ok = ~|lut_addr[LUT_ADDR_BW-1:VN_ADDR_BW];
	assign we_f0      = lut_we[LUT_F0] && vn_addr_ok; // out-of-range vn writes dropped
	assign we_f1      = lut_we[LUT_F1] && vn_addr_ok;
	assign we_dn      = lut_we[LUT_DN];

	////////////////////////////////////////////////////////////
	// stage chain

	row_stage_if #(.LANES(LANES)) s01 (); // f0 -> f1
	row_stage_if #(.LANES(LANES)) s12 (); // f1 -> dnu

	vnu_f0_stage #(.LANES(LANES)) u_f0 (
		.read_clk     (read_clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.ch_msg       (ch_msg),
		.c2v_0        (c2v_0),
		.c2v_1        (c2v_1),
		.c2v_2        (c2v_2),
		.c2v_to_dnu   (c2v_to_dnu),
		.dnu_sign_ext (dnu_sign_ext),
		.lut_we       (we_f0),
		.lut_addr     (lut_addr[VN_ADDR_BW-1:0]),
		.lut_data     (lut_data),
		.out          (s01)
	);

	vnu_f1_stage #(.LANES(LANES)) u_f1 (
		.read_clk (read_clk),
		.rst      (rst),
		.up       (s01),
		.dn       (s12),
		.lut_we   (we_f1),
		.lut_addr (lut_addr[VN_ADDR_BW-1:0]),
		.lut_data (lut_data)
	);

	dnu_stage #(.LANES(LANES)) u_dn (
		.read_clk      (read_clk),
		.rst           (rst),
		.up            (s12),
		.lut_we        (we_dn),
		.lut_addr      (lut_addr[DN_ADDR_BW-1:0]),
		.lut_data      (lut_data[0]), // decision tables are 1 bit wide
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.v2c           (v2c),
		.sign_gen      (sign_gen),
		.hard_decision (hard_decision)
	);

	////////////////////////////////////////////////////////////
	// occupancy, for write legality

	assign in_acc  = in_valid && in_ready;
	assign out_acc = out_valid && out_ready;

	always_ff @(posedge read_clk) begin
		if (rst) begin
			occ <= '0;
		end else if (in_acc && !out_acc) begin
			occ <= occ + 2'd1;
		end else if (out_acc && !in_acc) begin
			occ <= occ - 2'd1;
		end
	end

	// tables only change with nothing in flight and nothing arriving
	a_write_idle : assert property (@(posedge read_clk) disable iff (rst)
		|lut_we |-> occ == 2'd0 && !in_valid);

endmodule

`default_nettype wire

//--- verif/row_vnu_model.svh
`ifndef ROW_VNU_MODEL_SVH
`define ROW_VNU_MODEL_SVH

////////////////////////////////////////////////////////////
// IB table rules, sign-magnitude arithmetic

localparam int MSG_MAX = (1 << (QUAN_SIZE - 1)) - 1; // largest magnitude

// signed value of one message, -0 reads as 0
function automatic int sm_value(input msg_t m);
	int mag;
	mag = int'(m.sm.mag);
	return m.sm.sign ? -mag : mag;
endfunction

// back to sign-magnitude, saturated
function automatic msg_t sm_from_int(input int v);
	msg_t m;
	int   a;
	a = (v < 0) ? -v : v;
	if (a > MSG_MAX) begin
		a = MSG_MAX; // clip reliability
	end
	m.sm.sign = (v < 0); // zero always comes out as +0
	m.sm.mag  = a[QUAN_SIZE-2:0];
	return m;
endfunction

// f0 / f1 entry, saturated sum of the two address messages
function automatic msg_t vn_rule(input msg_t a, input msg_t b, input bit neg);
	int s;
	s = sm_value(a) + sm_value(b);
	if (neg) begin
		s = -s; // rewritten f1 table
	end
	return sm_from_int(s);
endfunction

// decision entry: sign of the sum, sign ext breaks the tie at zero
function automatic logic dn_rule(input logic sext, input msg_t c2, input msg_t cd);
	int s;
	s = sm_value(c2) + sm_value(cd);
	if (s < 0) begin
		return 1'b1;
	end else if (s > 0) begin
		return 1'b0;
	end
	return sext;
endfunction

////////////////////////////////////////////////////////////
// one item through f0, f1 and the decision node

task automatic model_item(
	input  lane_msgs_t       ch, c0, c1, c2, cd,
	input  logic [LANES-1:0] sext,
	input  bit               neg_f1,
	output lane_msgs_t       v2c_exp,
	output logic [LANES-1:0] hd_exp
);
	msg_t t;
	for (int l = 0; l < LANES; l++) begin
		t          = vn_rule(ch[l], c0[l], 1'b0); // f0 table always plain rule
		v2c_exp[l] = vn_rule(t, c1[l], neg_f1);
		hd_exp[l]  = dn_rule(sext[l], c2[l], cd[l]);
	end
endtask

`endif

//--- verif/row_vnu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module row_vnu_tb
	import ldpc_row_pkg::*;
();

	localparam int          LANES        = 10;
	localparam int          RESET_CYCLES = 16;
	localparam int          N_ITEMS      = 80;
	localparam int          N_PHASE_A    = 24; // back-to-back with ready high
	localparam int          N_PHASE_B    = 64; // random back-pressure up to here
	localparam int          LATENCY      = 3;
	localparam int          VN_DEPTH     = 1 << VN_ADDR_BW;
	localparam int          DN_DEPTH     = 1 << DN_ADDR_BW;
	localparam int          LOAD_CYCLES  = 2 * VN_DEPTH + DN_DEPTH + 16;
	localparam int          WD_CYCLES    = 20 * N_ITEMS + RESET_CYCLES + LOAD_CYCLES;
	localparam logic [31:0] SEED         = 32'he06ffcc4;

	typedef msg_t [LANES-1:0] lane_msgs_t;

	`include "row_vnu_model.svh"

	logic             clk;
	logic             rst;
	logic             in_valid;
	logic             in_ready;
	lane_msgs_t       ch_msg;
	lane_msgs_t       c2v_0;
	lane_msgs_t       c2v_1;
	lane_msgs_t       c2v_2;
	lane_msgs_t       c2v_to_dnu;
	logic [LANES-1:0] dnu_sign_ext;
	logic [2:0]       lut_we;
	logic [LUT_ADDR_BW-1:0] lut_addr;
	logic [QUAN_SIZE-1:0]   lut_data;
	logic             out_valid;
	logic             out_ready;
	lane_msgs_t       v2c;
	logic [LANES-1:0] sign_gen;
	logic [LANES-1:0] hard_decision;

	// stimulus table and expected results
	lane_msgs_t       st_ch   [N_ITEMS];
	lane_msgs_t       st_c0   [N_ITEMS];
	lane_msgs_t       st_c1   [N_ITEMS];
	lane_msgs_t       st_c2   [N_ITEMS];
	lane_msgs_t       st_cd   [N_ITEMS];
	logic [LANES-1:0] st_sext [N_ITEMS];
	bit               st_neg  [N_ITEMS]; // f1 table negated for this item
	bit               st_lat  [N_ITEMS]; // exact latency checked
	bit               st_zs   [N_ITEMS]; // zero-sum decision inputs
	lane_msgs_t       ex_v2c  [N_ITEMS];
	logic [LANES-1:0] ex_hd   [N_ITEMS];
	int               acc_cyc [N_ITEMS]; // edge that took the item

	int   cyc;
	int   out_idx;
	logic bp_en; // random out_ready on

	row_vnu_top #(.LANES(LANES)) dut (
		.read_clk      (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.ch_msg        (ch_msg),
		.c2v_0         (c2v_0),
		.c2v_1         (c2v_1),
		.c2v_2         (c2v_2),
		.c2v_to_dnu    (c2v_to_dnu),
		.dnu_sign_ext  (dnu_sign_ext),
		.lut_we        (lut_we),
		.lut_addr      (lut_addr),
		.lut_data      (lut_data),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.v2c           (v2c),
		.sign_gen      (sign_gen),
		.hard_decision (hard_decision)
	);

	////////////////////////////////////////////////////////////
	// checks

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_msg(input string name, input int item, input msg_t got, input msg_t exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t %s item %0d got %h expected %h",
				$time, name, item, got.idx, exp.idx);
			fail_run("message output differs from the model");
		end
	endtask

	task automatic check_bits(input string name, input int item,
		input logic [LANES-1:0] got, input logic [LANES-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t %s item %0d got %b expected %b",
				$time, name, item, got, exp);
			fail_run("lane bit output differs from the expected value");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t %s got %b expected %b", $time, name, got, exp);
			fail_run("handshake flag has the wrong level");
		end
	endtask

	task automatic check_count(input string name, input int item, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH time %0t %s item %0d got %0d expected %0d",
				$time, name, item, got, exp);
			fail_run("item took the wrong number of cycles");
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	function automatic msg_t rand_msg();
		msg_t m;
		m.idx = QUAN_SIZE'($urandom);
		return m;
	endfunction

	task automatic build_table();
		for (int i = 0; i < N_ITEMS; i++) begin
			st_neg[i] = (i >= N_PHASE_B);
			st_lat[i] = (i < N_PHASE_A) || (i >= N_PHASE_B); // no stalls there
			st_zs[i]  = (i == 5) || (i == 6) || (i == N_PHASE_A + 3) ||
				(i == N_PHASE_B) || (i == N_PHASE_B + 1);
			for (int l = 0; l < LANES; l++) begin
				st_ch[i][l] = rand_msg();
				st_c0[i][l] = rand_msg();
				st_c1[i][l] = rand_msg();
				st_c2[i][l] = rand_msg();
				st_cd[i][l] = rand_msg();
			end
			st_sext[i] = LANES'($urandom);
			case (i)
				0: begin // all zero
					st_ch[i] = '0;
					st_c0[i] = '0;
					st_c1[i] = '0;
					st_c2[i] = '0;
					st_cd[i] = '0;
				end
				1: begin // +7 everywhere so sums saturate
					st_ch[i] = {LANES{4'h7}};
					st_c0[i] = {LANES{4'h7}};
					st_c1[i] = {LANES{4'h7}};
					st_c2[i] = {LANES{4'h7}};
					st_cd[i] = {LANES{4'h7}};
				end
				2: begin // -7 everywhere
					st_ch[i] = {LANES{4'hf}};
					st_c0[i] = {LANES{4'hf}};
					st_c1[i] = {LANES{4'hf}};
					st_c2[i] = {LANES{4'hf}};
					st_cd[i] = {LANES{4'hf}};
				end
				3: begin // +7 and -7 cancel in f0
					st_ch[i] = {LANES{4'h7}};
					st_c0[i] = {LANES{4'hf}};
					st_c1[i] = {LANES{4'h7}};
				end
				4: begin // negative zero
					st_ch[i] = {LANES{4'h8}};
					st_c0[i] = {LANES{4'h8}};
					st_c1[i] = {LANES{4'h8}};
				end
				default: ;
			endcase
			if (st_zs[i]) begin
				for (int l = 0; l < LANES; l++) begin
					st_c2[i][l].sm.sign = 1'b0; // +m against -m
					st_cd[i][l].sm.sign = 1'b1;
					st_cd[i][l].sm.mag  = st_c2[i][l].sm.mag;
				end
			end
			model_item(st_ch[i], st_c0[i], st_c1[i], st_c2[i], st_cd[i], st_sext[i],
				st_neg[i], ex_v2c[i], ex_hd[i]);
		end
	endtask

	// f0 and/or f1 tables as selected by we
	task automatic load_vn_tables(input logic [2:0] we, input bit neg);
		msg_t hi;
		msg_t lo;
		msg_t d;
		for (int a = 0; a < VN_DEPTH; a++) begin
			hi.idx = a[2*QUAN_SIZE-1:QUAN_SIZE];
			lo.idx = a[QUAN_SIZE-1:0];
			d      = vn_rule(hi, lo, neg);
			@(posedge clk);
			lut_we   <= we;
			lut_addr <= a[LUT_ADDR_BW-1:0];
			lut_data <= d.idx;
		end
		@(posedge clk);
		lut_we <= '0;
	endtask

	task automatic load_dn_table();
		msg_t c2;
		msg_t cd;
		logic hd;
		for (int a = 0; a < DN_DEPTH; a++) begin
			c2.idx = a[2*QUAN_SIZE-1:QUAN_SIZE];
			cd.idx = a[QUAN_SIZE-1:0];
			hd     = dn_rule(a[DN_ADDR_BW-1], c2, cd); // top bit = sign ext
			@(posedge clk);
			lut_we   <= 3'b1 << LUT_DN;
			lut_addr <= a[LUT_ADDR_BW-1:0];
			lut_data <= {{(QUAN_SIZE-1){1'b0}}, hd};
		end
		@(posedge clk);
		lut_we <= '0;
	endtask

	task automatic send_range(input int first, input int last, input bit gaps);
		int gap;
		for (int i = first; i <= last; i++) begin
			@(posedge clk);
			in_valid     <= 1'b1;
			ch_msg       <= st_ch[i];
			c2v_0        <= st_c0[i];
			c2v_1        <= st_c1[i];
			c2v_2        <= st_c2[i];
			c2v_to_dnu   <= st_cd[i];
			dnu_sign_ext <= st_sext[i];
			@(negedge clk);
			while (!in_ready) begin
				@(negedge clk);
			end
			acc_cyc[i] = cyc + 1; // taken at the coming edge
			gap = gaps ? int'($urandom % 3) : 0;
			repeat (gap) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drained(input int n);
		while (out_idx < n) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk); // occupancy back to zero
	endtask

	////////////////////////////////////////////////////////////
	// clock, cycle count, back-pressure, watchdog

	initial begin : clock_gen
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin : cycle_count
		cyc = 0;
		forever begin
			@(posedge clk);
			cyc++;
		end
	end

	initial begin : backpressure
		out_ready <= 1'b1;
		forever begin
			@(posedge clk);
			if (bp_en) begin
				out_ready <= ($urandom % 4) != 0; // ready 3 of 4 cycles
			end else begin
				out_ready <= 1'b1;
			end
		end
	end

	initial begin : watchdog
		repeat (WD_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, %0d of %0d items out",
			WD_CYCLES, out_idx, N_ITEMS);
		fail_run("the run did not finish in time");
	end

	////////////////////////////////////////////////////////////
	// output monitor sampled mid-cycle

	initial begin : monitor
		logic [LANES-1:0] sg_exp;
		bit               fresh; // next valid cycle starts a new item
		fresh   = 1'b1;
		out_idx = 0;
		forever begin
			@(negedge clk);
			if (!rst && out_valid) begin
				if (out_idx >= N_ITEMS) begin
					fail_run("an output item appeared after all items were out");
				end else begin
					if (fresh && st_lat[out_idx]) begin
						// edge closing the first valid cycle against the input edge
						check_count("latency", out_idx, cyc + 1 - acc_cyc[out_idx], LATENCY);
					end
					fresh = 1'b0;
					if (out_ready) begin
						for (int l = 0; l < LANES; l++) begin
							check_msg($sformatf("v2c[%0d]", l), out_idx, v2c[l],
								ex_v2c[out_idx][l]);
							sg_exp[l] = ex_v2c[out_idx][l].sm.sign;
						end
						check_bits("sign_gen", out_idx, sign_gen, sg_exp);
						if (st_zs[out_idx]) begin // tie follows sign ext
							check_bits("hard_decision", out_idx, hard_decision,
								st_sext[out_idx]);
						end else begin
							check_bits("hard_decision", out_idx, hard_decision,
								ex_hd[out_idx]);
						end
						out_idx++;
						fresh = 1'b1;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence

	initial begin : main_seq
		void'($urandom(SEED));
		rst          <= 1'b1;
		in_valid     <= 1'b0;
		ch_msg       <= '0;
		c2v_0        <= '0;
		c2v_1        <= '0;
		c2v_2        <= '0;
		c2v_to_dnu   <= '0;
		dnu_sign_ext <= '0;
		lut_we       <= '0;
		lut_addr     <= '0;
		lut_data     <= '0;
		bp_en        <= 1'b0;
		build_table();

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);

		load_vn_tables((3'b1 << LUT_F0) | (3'b1 << LUT_F1), 1'b0); // same rule in one pass
		load_dn_table();

		send_range(0, N_PHASE_A - 1, 1'b0);
		wait_drained(N_PHASE_A);

		@(posedge clk);
		bp_en <= 1'b1;
		send_range(N_PHASE_A, N_PHASE_B - 1, 1'b1);
		@(posedge clk);
		bp_en <= 1'b0;
		wait_drained(N_PHASE_B);

		load_vn_tables(3'b1 << LUT_F1, 1'b1); // f1 negated while dn stays
		send_range(N_PHASE_B, N_ITEMS - 1, 1'b0);
		wait_drained(N_ITEMS);

		@(negedge clk);
		check_flag("out_valid", out_valid, 1'b0);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verif
src/ldpc_row_pkg.sv
src/row_stage_if.sv
src/ib_lut_ram.sv
src/vnu_f0_stage.sv
src/vnu_f1_stage.sv
src/dnu_stage.sv
src/row_vnu_top.sv
verif/row_vnu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := row_vnu_tb
RTL_TOP    := row_vnu_top
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
